//--- common/isa_dma_pkg.sv
package isa_dma_pkg;

	// ----------------------------------------
	// widths
	localparam int num_channels = 4;
	localparam int addr_w       = 16; // channel address and count
	localparam int page_w       = 8;
	localparam int mem_addr_w   = 24;
	localparam int data_w       = 8;

	// ----------------------------------------
	// controller register offsets, ports 00h-0Fh
	localparam logic [3:0] reg_status_cmd   = 4'h8;
	localparam logic [3:0] reg_request      = 4'h9;
	localparam logic [3:0] reg_single_mask  = 4'hA;
	localparam logic [3:0] reg_mode         = 4'hB;
	localparam logic [3:0] reg_clear_ff     = 4'hC;
	localparam logic [3:0] reg_master_clear = 4'hD;
	localparam logic [3:0] reg_clear_mask   = 4'hE;
	localparam logic [3:0] reg_all_mask     = 4'hF;

	// page ports 80h-8Fh, scattered as on the PC
	localparam logic [3:0] page_offset_ch0 = 4'h7;
	localparam logic [3:0] page_offset_ch1 = 4'h3;
	localparam logic [3:0] page_offset_ch2 = 4'h1;
	localparam logic [3:0] page_offset_ch3 = 4'h2;

	// mode register bits 3:2
	typedef enum logic [1:0] {
		xfer_verify      = 2'd0,
		xfer_to_memory   = 2'd1, // device to memory
		xfer_from_memory = 2'd2, // memory to device
		xfer_illegal     = 2'd3  // runs as verify
	} xfer_kind_e;

	typedef enum logic [2:0] {
		st_idle       = 3'd0,
		st_start      = 3'd1,
		st_read_wait  = 3'd2,
		st_read_data  = 3'd3,
		st_update     = 3'd4,
		st_done       = 3'd5,
		st_write_wait = 3'd6,
		st_verify     = 3'd7
	} chan_state_e;

	// ----------------------------------------
	// bundles
	typedef struct packed {
		logic [3:0]        address;
		logic              read;
		logic              write;
		logic [data_w-1:0] writedata;
	} io_req_t;

	typedef struct packed {
		logic              wr_address;
		logic              wr_count;
		logic              wr_mode;
		logic              high_byte; // byte flip-flop state
		logic [data_w-1:0] data;
	} chan_cmd_t;

	typedef struct packed {
		logic [addr_w-1:0] cur_address;
		logic [addr_w-1:0] cur_count;
		logic              busy;
		logic              tc; // one cycle, during the last update
		logic              auto_init;
	} chan_status_t;

	typedef struct packed {
		logic [addr_w-1:0] address;
		logic              read;
		logic              write;
		logic [data_w-1:0] writedata;
	} chan_bus_t;

	typedef struct packed {
		logic [mem_addr_w-1:0] address;
		logic                  read;
		logic                  write;
		logic [data_w-1:0]     writedata;
	} mem_req_t;

endpackage

//--- control/dma_control.sv
`timescale 1ns/10ps

module dma_control (
	input  logic                                                   clk,
	input  logic                                                   rst_n,
	input  isa_dma_pkg::io_req_t                                   io,
	output logic [isa_dma_pkg::data_w-1:0]                         readdata,
	output isa_dma_pkg::chan_cmd_t [isa_dma_pkg::num_channels-1:0] chan_cmd,
	output logic                                                   ch_reset,
	input  isa_dma_pkg::chan_status_t [isa_dma_pkg::num_channels-1:0] chan_status,
	input  logic [isa_dma_pkg::num_channels-1:0]                   dev_req,
	output logic [isa_dma_pkg::num_channels-1:0]                   grant
);
	logic                                 rd_last;
	logic                                 rd_valid;
	logic                                 flip_flop;
	logic [isa_dma_pkg::num_channels-1:0] pending;
	logic [isa_dma_pkg::num_channels-1:0] mask;
	logic [isa_dma_pkg::num_channels-1:0] terminated;
	logic [isa_dma_pkg::num_channels-1:0] tc;
	logic [isa_dma_pkg::num_channels-1:0] auto_init;
	logic [isa_dma_pkg::num_channels-1:0] busy;
	logic [isa_dma_pkg::num_channels-1:0] sel_bits; // channel picked by writedata[1:0]
	logic [isa_dma_pkg::num_channels-1:0] req_ok;
	isa_dma_pkg::chan_status_t            rd_chan;

	assign ch_reset = io.write && io.address == isa_dma_pkg::reg_master_clear;
	assign sel_bits = {{(isa_dma_pkg::num_channels - 1){1'b0}}, 1'b1} << io.writedata[1:0];
	assign rd_chan  = chan_status[io.address[2:1]];

	// ----------------------------------------
	// per-channel decode
	always_comb begin
		for (int i = 0; i < isa_dma_pkg::num_channels; i++) begin
			chan_cmd[i].wr_address = io.write && io.address == 4'(2 * i);
			chan_cmd[i].wr_count   = io.write && io.address == 4'(2 * i + 1);
			chan_cmd[i].wr_mode    = io.write && io.address == isa_dma_pkg::reg_mode &&
			                         io.writedata[1:0] == 2'(i);
			chan_cmd[i].high_byte  = flip_flop;
			chan_cmd[i].data       = io.writedata;
			tc[i]                  = chan_status[i].tc;
			auto_init[i]           = chan_status[i].auto_init;
			busy[i]                = chan_status[i].busy;
		end
	end

	// held read counts once
	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_last <= 1'b0;
		else
			rd_last <= io.read;
	end

	assign rd_valid = io.read && !rd_last;

	always_ff @(posedge clk) begin
		if (!rst_n || ch_reset)
			flip_flop <= 1'b0;
		else if (io.write && io.address == isa_dma_pkg::reg_clear_ff)
			flip_flop <= 1'b0;
		else if ((rd_valid || io.write) && !io.address[3])
			flip_flop <= ~flip_flop; // low byte, then high byte
	end

	// ----------------------------------------
	// request, mask, terminal count
	always_ff @(posedge clk) begin
		if (!rst_n || ch_reset)
			pending <= '0;
		else if (io.write && io.address == isa_dma_pkg::reg_request)
			pending <= io.writedata[2] ? (pending | sel_bits) : (pending & ~sel_bits);
		else
			pending <= dev_req;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || ch_reset)
			mask <= '1;
		else if (io.write && io.address == isa_dma_pkg::reg_clear_mask)
			mask <= '0;
		else if (io.write && io.address == isa_dma_pkg::reg_all_mask)
			mask <= io.writedata[3:0];
		else if (io.write && io.address == isa_dma_pkg::reg_single_mask)
			mask <= io.writedata[2] ? (mask | sel_bits) : (mask & ~sel_bits);
		else
			mask <= mask | (tc & ~auto_init); // single block ends masked
	end

	always_ff @(posedge clk) begin
		if (!rst_n || ch_reset)
			terminated <= '0;
		else if (rd_valid && io.address == isa_dma_pkg::reg_status_cmd)
			terminated <= '0;
		else
			terminated <= terminated | tc;
	end

	// ----------------------------------------
	// readback
	always_ff @(posedge clk) begin
		if (rd_valid) begin
			if (!io.address[3]) begin
				if (io.address[0])
					readdata <= flip_flop ? rd_chan.cur_count[15:8] : rd_chan.cur_count[7:0];
				else
					readdata <= flip_flop ? rd_chan.cur_address[15:8] : rd_chan.cur_address[7:0];
			end else begin
				case (io.address)
					isa_dma_pkg::reg_status_cmd: readdata <= {pending, terminated};
					isa_dma_pkg::reg_all_mask:   readdata <= {4'hF, mask};
					default:                     readdata <= '0;
				endcase
			end
		end
	end

	// fixed priority, channel 0 first
	assign req_ok = pending & ~mask;

	always_comb begin
		grant = '0;
		if (busy == '0) begin
			for (int i = isa_dma_pkg::num_channels - 1; i >= 0; i--) begin
				if (req_ok[i]) begin
					grant    = '0;
					grant[i] = 1'b1;
				end
			end
		end
	end

endmodule

//--- channel/dma_channel.sv
`timescale 1ns/10ps

module dma_channel (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           ch_reset,
	input  isa_dma_pkg::chan_cmd_t         cmd,
	input  logic                           grant,
	output isa_dma_pkg::chan_status_t      status,
	input  logic [isa_dma_pkg::data_w-1:0] dev_writedata,
	output logic                           dev_ack,
	output logic [isa_dma_pkg::data_w-1:0] dev_readdata,
	output logic                           dev_tc,
	output isa_dma_pkg::chan_bus_t         bus,
	input  logic                           mem_waitrequest,
	input  logic                           mem_readdatavalid,
	input  logic [isa_dma_pkg::data_w-1:0] mem_readdata
);
	logic [isa_dma_pkg::addr_w-1:0] base_address;
	logic [isa_dma_pkg::addr_w-1:0] cur_address;
	logic [isa_dma_pkg::addr_w-1:0] base_count;
	logic [isa_dma_pkg::addr_w-1:0] cur_count;
	logic [isa_dma_pkg::addr_w-1:0] xfer_address;
	logic [isa_dma_pkg::data_w-1:0] xfer_writedata;
	logic                           dec;
	logic                           auto_init;
	isa_dma_pkg::xfer_kind_e        kind;
	isa_dma_pkg::chan_state_e       state;
	logic                           issued;   // request has reached the memory port
	logic                           mem_done; // memory took the request
	logic                           update;
	logic                           tc;
	logic                           data_in;

	assign update   = state == isa_dma_pkg::st_update;
	assign tc       = update && cur_count == '0; // count wraps past zero
	assign mem_done = issued && !mem_waitrequest;
	assign data_in  = state == isa_dma_pkg::st_read_data && mem_readdatavalid;

	assign status.cur_address = cur_address;
	assign status.cur_count   = cur_count;
	assign status.busy        = state != isa_dma_pkg::st_idle;
	assign status.tc          = tc;
	assign status.auto_init   = auto_init;

	// ----------------------------------------
	// address and count
	always_ff @(posedge clk) begin
		if (cmd.wr_address) begin
			if (cmd.high_byte) begin
				base_address[15:8] <= cmd.data;
				cur_address[15:8]  <= cmd.data;
			end else begin
				base_address[7:0] <= cmd.data;
				cur_address[7:0]  <= cmd.data;
			end
		end else if (tc && auto_init) begin
			cur_address <= base_address;
		end else if (update) begin
			cur_address <= dec ? cur_address - 1'b1 : cur_address + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.wr_count) begin
			if (cmd.high_byte) begin
				base_count[15:8] <= cmd.data;
				cur_count[15:8]  <= cmd.data;
			end else begin
				base_count[7:0] <= cmd.data;
				cur_count[7:0]  <= cmd.data;
			end
		end else if (tc && auto_init) begin
			cur_count <= base_count;
		end else if (update) begin
			cur_count <= cur_count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec       <= 1'b0;
			auto_init <= 1'b0;
			kind      <= isa_dma_pkg::xfer_verify;
		end else if (cmd.wr_mode) begin
			dec       <= cmd.data[5];
			auto_init <= cmd.data[4];
			kind      <= isa_dma_pkg::xfer_kind_e'(cmd.data[3:2]);
		end
	end

	// ----------------------------------------
	// sequencer
	always_ff @(posedge clk) begin
		if (!rst_n || ch_reset) begin
			state  <= isa_dma_pkg::st_idle;
			issued <= 1'b0;
		end else begin
			issued <= 1'b0;
			case (state)
				isa_dma_pkg::st_idle:
					if (grant)
						state <= isa_dma_pkg::st_start;
				isa_dma_pkg::st_start:
					case (kind)
						isa_dma_pkg::xfer_to_memory:   state <= isa_dma_pkg::st_write_wait;
						isa_dma_pkg::xfer_from_memory: state <= isa_dma_pkg::st_read_wait;
						default:                       state <= isa_dma_pkg::st_verify;
					endcase
				isa_dma_pkg::st_read_wait: begin
					issued <= !mem_done;
					if (mem_done)
						state <= isa_dma_pkg::st_read_data;
				end
				isa_dma_pkg::st_read_data:
					if (mem_readdatavalid)
						state <= isa_dma_pkg::st_update;
				isa_dma_pkg::st_write_wait: begin
					issued <= !mem_done;
					if (mem_done)
						state <= isa_dma_pkg::st_update;
				end
				isa_dma_pkg::st_verify: state <= isa_dma_pkg::st_update;
				isa_dma_pkg::st_update: state <= isa_dma_pkg::st_done;
				default:                state <= isa_dma_pkg::st_idle; // st_done
			endcase
		end
	end

	// ack marks the end of the data phase
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dev_ack <= 1'b0;
			dev_tc  <= 1'b0;
		end else begin
			dev_ack <= data_in || state == isa_dma_pkg::st_verify ||
			           (state == isa_dma_pkg::st_write_wait && mem_done);
			dev_tc  <= tc;
		end
	end

	always_ff @(posedge clk) begin
		if (data_in)
			dev_readdata <= mem_readdata;
	end

	// address and data captured at start
	always_ff @(posedge clk) begin
		if (state == isa_dma_pkg::st_start) begin
			xfer_address   <= cur_address;
			xfer_writedata <= dev_writedata;
		end
	end

	// strobes drop in the cycle the memory accepts
	always_comb begin
		bus = '0;
		if (state != isa_dma_pkg::st_idle) begin
			bus.address   = xfer_address;
			bus.writedata = xfer_writedata;
		end
		bus.read  = state == isa_dma_pkg::st_read_wait && !mem_done;
		bus.write = state == isa_dma_pkg::st_write_wait && !mem_done;
	end

endmodule

//--- mem_port/dma_mem_port.sv
`timescale 1ns/10ps

module dma_mem_port (
	input  logic                                                   clk,
	input  logic                                                   rst_n,
	input  isa_dma_pkg::io_req_t                                   page_io,
	output logic [isa_dma_pkg::data_w-1:0]                         page_readdata,
	input  isa_dma_pkg::chan_bus_t [isa_dma_pkg::num_channels-1:0] chan_bus,
	input  logic [isa_dma_pkg::num_channels-1:0]                   busy,
	output isa_dma_pkg::mem_req_t                                  mem
);
	logic [isa_dma_pkg::num_channels-1:0][isa_dma_pkg::page_w-1:0] page;
	logic [isa_dma_pkg::page_w-1:0]                                page_sel;
	isa_dma_pkg::chan_bus_t                                        merged;

	// ----------------------------------------
	// page registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			page <= '0;
		end else if (page_io.write) begin
			case (page_io.address)
				isa_dma_pkg::page_offset_ch0: page[0] <= page_io.writedata;
				isa_dma_pkg::page_offset_ch1: page[1] <= page_io.writedata;
				isa_dma_pkg::page_offset_ch2: page[2] <= page_io.writedata;
				isa_dma_pkg::page_offset_ch3: page[3] <= page_io.writedata;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (page_io.read) begin
			case (page_io.address)
				isa_dma_pkg::page_offset_ch0: page_readdata <= page[0];
				isa_dma_pkg::page_offset_ch1: page_readdata <= page[1];
				isa_dma_pkg::page_offset_ch2: page_readdata <= page[2];
				isa_dma_pkg::page_offset_ch3: page_readdata <= page[3];
				default:                      page_readdata <= '0; // unused ports
			endcase
		end
	end

	// ----------------------------------------
	// idle channels drive zero, so OR merges
	always_comb begin
		merged   = '0;
		page_sel = '0;
		for (int i = 0; i < isa_dma_pkg::num_channels; i++) begin
			merged = merged | chan_bus[i];
			if (busy[i])
				page_sel = page[i];
		end
	end

	always_ff @(posedge clk) begin
		mem.address   <= {page_sel, merged.address};
		mem.writedata <= merged.writedata;
		if (!rst_n) begin
			mem.read  <= 1'b0;
			mem.write <= 1'b0;
		end else begin
			mem.read  <= (busy != '0) && merged.read;
			mem.write <= (busy != '0) && merged.write;
		end
	end

endmodule

//--- src/isa_dma.sv
`timescale 1ns/10ps

module isa_dma (
	input  logic                                                      clk,
	input  logic                                                      rst_n,
	input  isa_dma_pkg::io_req_t                                      io,
	input  logic                                                      io_dma_cs,
	input  logic                                                      io_page_cs,
	output logic [isa_dma_pkg::data_w-1:0]                            io_readdata,
	input  logic [isa_dma_pkg::num_channels-1:0]                      dev_req,
	input  logic [isa_dma_pkg::num_channels-1:0][isa_dma_pkg::data_w-1:0] dev_writedata,
	output logic [isa_dma_pkg::num_channels-1:0]                      dev_ack,
	output logic [isa_dma_pkg::num_channels-1:0]                      dev_tc,
	output logic [isa_dma_pkg::num_channels-1:0][isa_dma_pkg::data_w-1:0] dev_readdata,
	output isa_dma_pkg::mem_req_t                                     mem,
	input  logic                                                      mem_waitrequest,
	input  logic                                                      mem_readdatavalid,
	input  logic [isa_dma_pkg::data_w-1:0]                            mem_readdata
);
	isa_dma_pkg::io_req_t                                         ctl_io;
	isa_dma_pkg::io_req_t                                         page_io;
	isa_dma_pkg::chan_cmd_t    [isa_dma_pkg::num_channels-1:0]    chan_cmd;
	isa_dma_pkg::chan_status_t [isa_dma_pkg::num_channels-1:0]    chan_status;
	isa_dma_pkg::chan_bus_t    [isa_dma_pkg::num_channels-1:0]    chan_bus;
	logic [isa_dma_pkg::num_channels-1:0]                         grant;
	logic [isa_dma_pkg::num_channels-1:0]                         busy;
	logic [isa_dma_pkg::data_w-1:0]                               ctl_readdata;
	logic [isa_dma_pkg::data_w-1:0]                               page_readdata;
	logic                                                         ch_reset;
	logic                                                         rd_page; // last read hit the pages

	// qualify strobes with their select
	always_comb begin
		ctl_io        = io;
		ctl_io.read   = io.read & io_dma_cs;
		ctl_io.write  = io.write & io_dma_cs;
		page_io       = io;
		page_io.read  = io.read & io_page_cs;
		page_io.write = io.write & io_page_cs;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_page <= 1'b0;
		else if (ctl_io.read || page_io.read)
			rd_page <= io_page_cs;
	end

	assign io_readdata = rd_page ? page_readdata : ctl_readdata;

	dma_control i_dma_control (
		.clk         (clk),
		.rst_n       (rst_n),
		.io          (ctl_io),
		.readdata    (ctl_readdata),
		.chan_cmd    (chan_cmd),
		.ch_reset    (ch_reset),
		.chan_status (chan_status),
		.dev_req     (dev_req),
		.grant       (grant)
	);

	// ----------------------------------------
	// channel engines
	for (genvar i = 0; i < isa_dma_pkg::num_channels; i++) begin : g_chan
		assign busy[i] = chan_status[i].busy;

		dma_channel i_dma_channel (
			.clk               (clk),
			.rst_n             (rst_n),
			.ch_reset          (ch_reset),
			.cmd               (chan_cmd[i]),
			.grant             (grant[i]),
			.status            (chan_status[i]),
			.dev_writedata     (dev_writedata[i]),
			.dev_ack           (dev_ack[i]),
			.dev_readdata      (dev_readdata[i]),
			.dev_tc            (dev_tc[i]),
			.bus               (chan_bus[i]),
			.mem_waitrequest   (mem_waitrequest),
			.mem_readdatavalid (mem_readdatavalid),
			.mem_readdata      (mem_readdata)
		);
	end

	dma_mem_port i_dma_mem_port (
		.clk           (clk),
		.rst_n         (rst_n),
		.page_io       (page_io),
		.page_readdata (page_readdata),
		.chan_bus      (chan_bus),
		.busy          (busy),
		.mem           (mem)
	);

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// reset held low for two cycles
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

//--- tests/tb_isa_dma.sv
`timescale 1ns/10ps

module tb_isa_dma;
	localparam int n_ch  = isa_dma_pkg::num_channels;
	localparam int limit = 2000;

	logic                      clk;
	logic                      rst_n;
	isa_dma_pkg::io_req_t      io;
	logic                      io_dma_cs;
	logic                      io_page_cs;
	logic [7:0]                io_readdata;
	logic [n_ch-1:0]           dev_req;
	logic [n_ch-1:0]           dev_ack;
	logic [n_ch-1:0]           dev_tc;
	logic [n_ch-1:0][7:0]      dev_writedata;
	logic [n_ch-1:0][7:0]      dev_readdata;
	isa_dma_pkg::mem_req_t     mem;
	logic                      mem_waitrequest;
	logic                      mem_readdatavalid;
	logic [7:0]                mem_readdata;

	logic [7:0]                mem_store [int];
	int                        wait_left;
	int                        rd_delay;
	logic                      rd_pending;
	logic [23:0]               rd_addr;
	logic [7:0]                mem_salt;
	logic [7:0]                dev_salt;

	// what each channel was programmed with
	logic [7:0]                exp_page [n_ch];
	logic [15:0]               exp_base [n_ch];
	int                        exp_len [n_ch];
	logic                      exp_dec [n_ch];
	isa_dma_pkg::xfer_kind_e   exp_kind [n_ch];
	int                        xfer_idx [n_ch];
	int                        ack_count [n_ch];
	int                        tc_count [n_ch];
	int                        req_left [n_ch];
	int                        ack_log [$];
	int                        checks;
	int                        errors;

	tb_clock_gen i_tb_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	isa_dma i_isa_dma (
		.clk               (clk),
		.rst_n             (rst_n),
		.io                (io),
		.io_dma_cs         (io_dma_cs),
		.io_page_cs        (io_page_cs),
		.io_readdata       (io_readdata),
		.dev_req           (dev_req),
		.dev_writedata     (dev_writedata),
		.dev_ack           (dev_ack),
		.dev_tc            (dev_tc),
		.dev_readdata      (dev_readdata),
		.mem               (mem),
		.mem_waitrequest   (mem_waitrequest),
		.mem_readdatavalid (mem_readdatavalid),
		.mem_readdata      (mem_readdata)
	);

	// ----------------------------------------
	// reference model
	function automatic logic [23:0] expected_address(input logic [7:0] page,
		input logic [15:0] base, input int index, input logic dec, input int block_len);
		logic [15:0] step;
		step = 16'(index % block_len); // autoinit restarts the block
		return {page, dec ? base - step : base + step};
	endfunction

	function automatic logic [7:0] fill_byte(input logic [23:0] addr);
		return addr[23:16] ^ addr[15:8] ^ {addr[6:0], addr[7]} ^ mem_salt;
	endfunction

	function automatic logic [7:0] dev_byte(input int ch, input int k);
		return dev_salt + 8'(ch * 64) + 8'(k * 29);
	endfunction

	// lowest channel still requesting is the one served
	function automatic int active_channel();
		int ch;
		ch = -1;
		for (int i = n_ch - 1; i >= 0; i--)
			if (req_left[i] != 0)
				ch = i;
		return ch;
	endfunction

	function automatic logic [3:0] page_port(input int ch);
		case (ch)
			0:       return isa_dma_pkg::page_offset_ch0;
			1:       return isa_dma_pkg::page_offset_ch1;
			2:       return isa_dma_pkg::page_offset_ch2;
			default: return isa_dma_pkg::page_offset_ch3;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	endtask

	// ----------------------------------------
	// memory model, random wait and read latency
	always @(posedge clk) begin
		mem_readdatavalid <= 1'b0;
		if (rd_pending) begin
			if (rd_delay == 0) begin
				rd_pending = 1'b0;
				mem_readdatavalid <= 1'b1;
				mem_readdata <= mem_store.exists(int'(rd_addr)) ? mem_store[int'(rd_addr)] :
				                fill_byte(rd_addr);
			end else begin
				rd_delay--;
			end
		end
		if ((mem.read || mem.write) && !mem_waitrequest) begin
			mem_waitrequest <= 1'b1; // next request starts stalled
			wait_left = $urandom_range(3, 0);
			if (mem.write) begin
				mem_store[int'(mem.address)] = mem.writedata;
			end else begin
				rd_pending = 1'b1;
				rd_addr    = mem.address;
				rd_delay   = $urandom_range(3, 0);
			end
		end else if (mem.read || mem.write) begin
			if (wait_left == 0)
				mem_waitrequest <= 1'b0;
			else
				wait_left--;
		end
	end

	// device side and compare
	always @(posedge clk) begin : compare
		int          ch;
		logic [23:0] exp_addr;
		if (rst_n) begin
			if ((mem.read || mem.write) && !mem_waitrequest) begin
				ch = active_channel();
				if (ch < 0) begin
					errors++;
					$display("memory access at %06h with no channel requesting", mem.address);
				end else begin
					exp_addr = expected_address(exp_page[ch], exp_base[ch], xfer_idx[ch],
					                            exp_dec[ch], exp_len[ch]);
					check_value("memory address", exp_addr, mem.address);
					check_value("memory direction",
					            exp_kind[ch] == isa_dma_pkg::xfer_to_memory, mem.write);
					if (mem.write)
						check_value("memory write data", dev_byte(ch, ack_count[ch]),
						            mem.writedata);
				end
			end
			for (int i = 0; i < n_ch; i++) begin
				if (dev_ack[i]) begin
					if (req_left[i] == 0) begin
						errors++;
						$display("channel %0d acknowledged without a request", i);
					end else if (exp_kind[i] == isa_dma_pkg::xfer_from_memory) begin
						exp_addr = expected_address(exp_page[i], exp_base[i], xfer_idx[i],
						                            exp_dec[i], exp_len[i]);
						check_value("device read data", fill_byte(exp_addr), dev_readdata[i]);
					end
					ack_count[i]++;
					xfer_idx[i]++;
					ack_log.push_back(i);
					if (req_left[i] > 0)
						req_left[i]--;
				end
				if (dev_tc[i]) begin
					tc_count[i]++;
					check_value("tc after last transfer", 0, xfer_idx[i] % exp_len[i]);
				end
				dev_req[i]       <= req_left[i] != 0; // drop once the block is delivered
				dev_writedata[i] <= dev_byte(i, ack_count[i]);
			end
		end
	end

	// ----------------------------------------
	// bus tasks
	task automatic io_write(input logic page, input logic [3:0] address, input logic [7:0] data);
		@(posedge clk);
		io.address   <= address;
		io.writedata <= data;
		io.write     <= 1'b1;
		io_dma_cs    <= !page;
		io_page_cs   <= page;
		@(posedge clk);
		io.write   <= 1'b0;
		io_dma_cs  <= 1'b0;
		io_page_cs <= 1'b0;
	endtask

	task automatic io_read(input logic page, input logic [3:0] address, output logic [7:0] data);
		@(posedge clk);
		io.address <= address;
		io.read    <= 1'b1;
		io_dma_cs  <= !page;
		io_page_cs <= page;
		@(posedge clk);
		io.read <= 1'b0;
		@(posedge clk);
		data = io_readdata; // registered, select still held
		io_dma_cs  <= 1'b0;
		io_page_cs <= 1'b0;
	endtask

	task automatic program_channel(input int ch, input logic [15:0] base,
		input logic [15:0] count, input logic dec, input logic auto_init,
		input isa_dma_pkg::xfer_kind_e kind);
		io_write(1'b0, isa_dma_pkg::reg_clear_ff, 8'h00);
		io_write(1'b0, 4'(2 * ch), base[7:0]);
		io_write(1'b0, 4'(2 * ch), base[15:8]);
		io_write(1'b0, 4'(2 * ch + 1), count[7:0]);
		io_write(1'b0, 4'(2 * ch + 1), count[15:8]);
		io_write(1'b0, isa_dma_pkg::reg_mode, {2'b01, dec, auto_init, kind, 2'(ch)});
		exp_base[ch] = base;
		exp_len[ch]  = int'(count) + 1;
		exp_dec[ch]  = dec;
		exp_kind[ch] = kind;
		xfer_idx[ch] = 0;
		io_write(1'b0, isa_dma_pkg::reg_single_mask, 8'(ch)); // clear this mask bit
	endtask

	task automatic start_requests(input int ch, input int n);
		@(negedge clk);
		req_left[ch] = n;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic wait_tc(input int ch, input int target);
		int cycles;
		cycles = 0;
		while (tc_count[ch] < target && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (tc_count[ch] < target) begin
			errors++;
			$display("channel %0d did not reach terminal count in time", ch);
			finish_run();
		end
	endtask

	// ----------------------------------------
	// stimulus
	initial begin
		logic [7:0]  rd;
		logic [15:0] base;
		logic [15:0] count;
		int          cycles;
		int          prev;
		int          seed;

		seed              = $urandom(32'h4c2a58d3);
		io                = '0;
		io_dma_cs         = 1'b0;
		io_page_cs        = 1'b0;
		dev_req           = '0;
		dev_writedata     = '0;
		mem_waitrequest   = 1'b1;
		mem_readdatavalid = 1'b0;
		mem_readdata      = '0;
		rd_pending        = 1'b0;
		rd_delay          = 0;
		rd_addr           = '0;
		wait_left         = $urandom_range(3, 0);
		mem_salt          = 8'($urandom);
		dev_salt          = 8'($urandom);
		checks            = 0;
		errors            = 0;
		for (int i = 0; i < n_ch; i++) begin
			exp_page[i]  = {2'(i), 6'($urandom)}; // distinct per channel
			exp_base[i]  = '0;
			exp_len[i]   = 1;
			exp_dec[i]   = 1'b0;
			exp_kind[i]  = isa_dma_pkg::xfer_verify;
			xfer_idx[i]  = 0;
			ack_count[i] = 0;
			tc_count[i]  = 0;
			req_left[i]  = 0;
		end

		cycles = 0;
		while (!rst_n && cycles < 10) begin
			@(posedge clk);
			cycles++;
		end
		if (!rst_n) begin
			errors++;
			$display("reset was never released");
			finish_run();
		end

		// register programming and master clear
		io_write(1'b0, isa_dma_pkg::reg_clear_mask, 8'h00);
		io_read(1'b0, isa_dma_pkg::reg_all_mask, rd);
		check_value("cleared mask", 4'h0, rd[3:0]);
		io_write(1'b0, isa_dma_pkg::reg_master_clear, 8'h00);
		io_read(1'b0, isa_dma_pkg::reg_all_mask, rd);
		check_value("master clear mask", 4'hF, rd[3:0]);
		base  = 16'($urandom);
		count = 16'($urandom);
		io_write(1'b0, isa_dma_pkg::reg_clear_ff, 8'h00);
		io_write(1'b0, 4'h2, base[7:0]);
		io_write(1'b0, 4'h2, base[15:8]);
		io_write(1'b0, 4'h3, count[7:0]);
		io_write(1'b0, 4'h3, count[15:8]);
		io_write(1'b0, isa_dma_pkg::reg_clear_ff, 8'h00);
		io_read(1'b0, 4'h2, rd);
		check_value("address low byte", base[7:0], rd);
		io_read(1'b0, 4'h2, rd);
		check_value("address high byte", base[15:8], rd);
		io_read(1'b0, 4'h3, rd);
		check_value("count low byte", count[7:0], rd);
		io_read(1'b0, 4'h3, rd);
		check_value("count high byte", count[15:8], rd);

		// page registers at 87, 83, 81, 82
		for (int i = 0; i < n_ch; i++)
			io_write(1'b1, page_port(i), exp_page[i]);
		for (int i = 0; i < n_ch; i++) begin
			io_read(1'b1, page_port(i), rd);
			check_value("page readback", exp_page[i], rd);
		end

		// device to memory on channel 0, one block
		program_channel(0, 16'($urandom), 16'd5, 1'b0, 1'b0, isa_dma_pkg::xfer_to_memory);
		start_requests(0, 6);
		wait_tc(0, 1);
		idle_cycles(4);
		check_value("channel 0 tc pulses", 1, tc_count[0]);
		check_value("channel 0 transfers", 6, xfer_idx[0]);
		io_read(1'b0, isa_dma_pkg::reg_all_mask, rd);
		check_value("mask set after tc", 1, rd[0]);
		io_read(1'b0, isa_dma_pkg::reg_status_cmd, rd);
		check_value("terminated bit", 1, rd[0]);
		io_read(1'b0, isa_dma_pkg::reg_status_cmd, rd);
		check_value("terminated bit after read", 0, rd[0]);

		// memory to device on channel 3, decrementing
		program_channel(3, 16'($urandom), 16'd4, 1'b1, 1'b0, isa_dma_pkg::xfer_from_memory);
		start_requests(3, 5);
		wait_tc(3, 1);
		idle_cycles(4);
		check_value("channel 3 transfers", 5, xfer_idx[3]);

		// ----------------------------------------
		// channel 1 beats channel 2
		program_channel(1, 16'($urandom), 16'd2, 1'b0, 1'b0, isa_dma_pkg::xfer_to_memory);
		program_channel(2, 16'($urandom), 16'd2, 1'b0, 1'b0, isa_dma_pkg::xfer_to_memory);
		ack_log.delete();
		@(negedge clk);
		req_left[1] = 3;
		req_left[2] = 3;
		wait_tc(1, 1);
		wait_tc(2, 1);
		idle_cycles(4);
		check_value("priority ack total", 6, ack_log.size());
		for (int k = 0; k < ack_log.size(); k++)
			check_value("priority order", k < 3 ? 1 : 2, ack_log[k]);

		// masked channel stays silent
		io_write(1'b0, isa_dma_pkg::reg_single_mask, 8'h07);
		prev = ack_count[3];
		start_requests(3, 1);
		idle_cycles(40);
		check_value("masked channel acks", prev, ack_count[3]);
		start_requests(3, 0);

		// autoinit, two blocks on channel 0
		program_channel(0, 16'($urandom), 16'd2, 1'b0, 1'b1, isa_dma_pkg::xfer_to_memory);
		prev = tc_count[0];
		start_requests(0, 6);
		wait_tc(0, prev + 2);
		idle_cycles(4);
		check_value("autoinit transfers", 6, xfer_idx[0]);
		io_read(1'b0, isa_dma_pkg::reg_all_mask, rd);
		check_value("autoinit mask", 0, rd[0]);

		finish_run();
	end

endmodule

//--- isa_dma.f
common/isa_dma_pkg.sv
control/dma_control.sv
channel/dma_channel.sv
mem_port/dma_mem_port.sv
src/isa_dma.sv
tests/tb_clock_gen.sv
tests/tb_isa_dma.sv
